//--- build.f
logic/i2c_pkg.sv
logic/apb_regs.sv
logic/byte_fifo.sv
logic/i2c_bit_engine.sv
logic/i2c_master_top.sv
bench/tb_clock.sv
bench/i2c_master_chk.sv
bench/tb_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    localparam logic [6:0] own_addr = 7'h52;
    localparam int m_idle = 0, m_addr = 1, m_wr = 2, m_ack = 3, m_rd = 4, m_mack = 5;
    // Rough bit count of all transfers, 8 pclk per bit at prescale 1
    localparam int total_bits = 300;
    localparam int cycle_limit = total_bits * 8 + 4000;
    localparam realtime scl_period = 80.0;

    logic       pclk;
    logic       arst_n;
    logic       psel;
    logic       penable;
    logic       pwrite;
    logic [2:0] paddr;
    logic [7:0] pwdata;
    logic [7:0] prdata;
    logic       pready;
    logic       scl_out;
    logic       sda_out;
    logic       model_drive;
    wire        sda_line = sda_out & model_drive;

    logic [31:0] lfsr = 32'h3ccb587d;
    int          cycles = 0;
    int          scl_low_cycles = 0;
    bit          check_period = 1'b1;
    realtime     last_rise = -1.0;

    int         mode = m_idle;
    int         bit_n;
    logic [7:0] sr;
    logic [7:0] cur;
    logic [7:0] addr_seen;
    int         start_cnt;
    int         stop_cnt;
    int         scl_rises;
    logic [7:0] wr_bytes[$];
    logic [7:0] sent[$];
    logic       mack[$];
    logic [7:0] exp_q[$];

    tb_clock clk_gen (.pclk(pclk), .arst_n(arst_n));

    i2c_master_top uut (
        .pclk(pclk), .arst_n(arst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .scl_out(scl_out), .sda_out(sda_out), .sda_in(sda_line)
    );

    task automatic fail_now(input string msg);
        $display("Fail %0t: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    // Galois LFSR, one step per bit
    task automatic take_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
    endtask

    task automatic apb_write(input logic [2:0] a, input logic [7:0] d);
        @(posedge pclk);
        psel    <= 1'b1;
        pwrite  <= 1'b1;
        penable <= 1'b0;
        paddr   <= a;
        pwdata  <= d;
        @(posedge pclk);
        penable <= 1'b1;
        @(posedge pclk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [2:0] a, output logic [7:0] d);
        @(posedge pclk);
        psel    <= 1'b1;
        pwrite  <= 1'b0;
        penable <= 1'b0;
        paddr   <= a;
        @(posedge pclk);
        penable <= 1'b1;
        @(negedge pclk);
        d = prdata;
        @(posedge pclk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic wait_idle();
        logic [7:0] st;
        do apb_read(i2c_pkg::reg_status, st);
        while (st[i2c_pkg::st_busy]);
    endtask

    task automatic clear_model();
        wr_bytes.delete();
        sent.delete();
        mack.delete();
        start_cnt = 0;
        stop_cnt  = 0;
        scl_rises = 0;
    endtask

    task automatic pop_and_compare(input int n);
        logic [7:0] d;
        for (int i = 0; i < n; i++) begin
            apb_read(i2c_pkg::reg_receive, d);
            assert (d == exp_q[0]) else fail_now("receive byte mismatch");
            void'(exp_q.pop_front());
        end
    endtask

    always @(posedge pclk) begin
        cycles <= cycles + 1;
        scl_low_cycles <= scl_out ? 0 : scl_low_cycles + 1;
        if (cycles == cycle_limit) begin
            $display("Timeout: the run took longer than the cycle limit");
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

    // I2C target model
    always @(negedge sda_line) begin
        if (arst_n && scl_out) begin
            mode = m_addr;
            bit_n = 0;
            start_cnt++;
            last_rise = -1.0;
        end
    end

    always @(posedge sda_line) begin
        if (arst_n && scl_out) begin
            stop_cnt++;
            mode = m_idle;
            model_drive = 1'b1;
        end
    end

    always @(posedge scl_out) begin
        if (arst_n && check_period && last_rise >= 0.0) begin
            assert ($realtime - last_rise == scl_period) else fail_now("SCL period wrong");
        end
        last_rise = $realtime;
        scl_rises++;
        if (mode == m_addr || mode == m_wr) begin
            sr = {sr[6:0], sda_line};
            bit_n++;
        end else if (mode == m_mack) begin
            mack.push_back(sda_line);
        end
    end

    always @(negedge scl_out) begin
        case (mode)
            m_addr: if (bit_n == 8) begin
                addr_seen = sr;
                if (sr[7:1] == own_addr) begin
                    model_drive = 1'b0;
                    mode = m_ack;
                end else mode = m_idle;
            end
            m_wr: if (bit_n == 8) begin
                wr_bytes.push_back(sr);
                model_drive = 1'b0;
                mode = m_ack;
            end
            m_ack: begin
                model_drive = 1'b1;
                bit_n = 0;
                mode = m_wr;
                if (addr_seen[0]) begin
                    take_byte(cur);
                    sent.push_back(cur);
                    model_drive = cur[7];
                    bit_n = 1;
                    mode = m_rd;
                end
            end
            m_rd: if (bit_n == 8) begin
                model_drive = 1'b1;
                mode = m_mack;
            end else begin
                model_drive = cur[7-bit_n];
                bit_n++;
            end
            m_mack: if (mack[$] == 1'b0) begin
                take_byte(cur);
                sent.push_back(cur);
                model_drive = cur[7];
                bit_n = 1;
                mode = m_rd;
            end else mode = m_idle;
            default: ;
        endcase
    end

    initial begin
        logic [7:0] b;
        logic [7:0] st;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        model_drive = 1'b1;
        @(posedge arst_n);
        apb_write(i2c_pkg::reg_prescale, 8'd1);
        apb_write(i2c_pkg::reg_address, {1'b0, own_addr});

        // Write of three bytes
        clear_model();
        exp_q.delete();
        for (int i = 0; i < 3; i++) begin
            take_byte(b);
            exp_q.push_back(b);
            apb_write(i2c_pkg::reg_transmit, b);
        end
        apb_write(i2c_pkg::reg_command, 8'h01);
        wait_idle();
        assert (start_cnt == 1 && stop_cnt == 1) else fail_now("write START/STOP count");
        assert (addr_seen == {own_addr, 1'b0}) else fail_now("write address byte");
        assert (wr_bytes == exp_q) else fail_now("written bytes differ");

        // Read of four bytes
        clear_model();
        apb_write(i2c_pkg::reg_command, 8'h33);
        wait_idle();
        assert (sent.size() == 4) else fail_now("read byte count");
        assert (mack.size() == 4 && mack[0] == 0 && mack[1] == 0 && mack[2] == 0 && mack[3] == 1)
            else fail_now("master ACK/NACK pattern");
        exp_q = sent;
        pop_and_compare(4);

        // Address NACK with a byte waiting, then a good transfer
        clear_model();
        apb_write(i2c_pkg::reg_transmit, 8'h5a);
        apb_write(i2c_pkg::reg_address, 8'h11);
        apb_write(i2c_pkg::reg_command, 8'h01);
        wait_idle();
        apb_read(i2c_pkg::reg_status, st);
        assert (st[i2c_pkg::st_nack]) else fail_now("nack not set");
        // Eight address bits, the ACK slot and the STOP
        assert (wr_bytes.size() == 0 && start_cnt == 1 && stop_cnt == 1 && scl_rises == 10)
            else fail_now("no STOP right after address");
        apb_write(i2c_pkg::reg_address, {1'b0, own_addr});
        apb_write(i2c_pkg::reg_command, 8'h01);
        wait_idle();
        apb_read(i2c_pkg::reg_status, st);
        assert (!st[i2c_pkg::st_nack]) else fail_now("nack not cleared");
        assert (wr_bytes.size() == 1 && wr_bytes[0] == 8'h5a)
            else fail_now("byte not kept over the NACK transfer");

        // FIFO limits
        clear_model();
        exp_q.delete();
        for (int i = 0; i < 9; i++) begin
            take_byte(b);
            if (i < 8) exp_q.push_back(b);
            apb_write(i2c_pkg::reg_transmit, b);
            apb_read(i2c_pkg::reg_status, st);
            assert (st[i2c_pkg::st_tx_full] == (i >= 7)) else fail_now("tx_full flag");
        end
        apb_write(i2c_pkg::reg_command, 8'h01);
        wait_idle();
        assert (wr_bytes == exp_q) else fail_now("full FIFO transfer bytes");
        apb_read(i2c_pkg::reg_receive, b);
        assert (b == 8'h00) else fail_now("empty receive read not zero");
        apb_read(i2c_pkg::reg_status, st);
        assert (st[i2c_pkg::st_rx_empty]) else fail_now("rx_empty not set");

        // Back-pressure on a ten byte read
        clear_model();
        check_period = 1'b0;
        apb_write(i2c_pkg::reg_command, 8'h93);
        while (scl_low_cycles < 64) @(posedge pclk);
        assert (scl_out == 1'b0 && sent.size() == 9) else fail_now("no stall after FIFO filled");
        exp_q = sent;
        pop_and_compare(8);
        wait_idle();
        assert (sent.size() == 10) else fail_now("stalled read byte count");
        exp_q.push_back(sent[9]);
        pop_and_compare(2);

        $display("TEST PASS");
        $finish;
    end

endmodule

//--- bench/i2c_master_chk.sv
`timescale 1ns/1ps

module i2c_master_chk (
    input logic pclk,
    input logic arst_n,
    input logic scl_out,
    input logic sda_out,
    input logic pready,
    input logic busy,
    input logic start_pulse
);

    logic seen_low;
    logic started;

    // seen_low marks that SCL has gone low since the transfer began
    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            seen_low <= 1'b0;
            started  <= 1'b0;
        end else begin
            if (start_pulse) started <= 1'b1;
            if (!busy) seen_low <= 1'b0;
            else if (!scl_out) seen_low <= 1'b1;
        end
    end

    // Fall with SCL high is only START, before any SCL low
    assert property (@(posedge pclk) disable iff (!arst_n)
        ($fell(sda_out) && scl_out && $past(scl_out)) |-> !seen_low)
        else $error("SDA fell while SCL high outside START");

    // Rise with SCL high is only STOP, after the bits
    assert property (@(posedge pclk) disable iff (!arst_n)
        ($rose(sda_out) && scl_out && $past(scl_out)) |-> seen_low)
        else $error("SDA rose while SCL high outside STOP");

    assert property (@(posedge pclk) disable iff (!arst_n) pready == 1'b1)
        else $error("pready dropped");

    assert property (@(posedge pclk) disable iff (!arst_n) !started |-> !busy)
        else $error("busy before first start");

    assert property (@(posedge pclk) disable iff (!arst_n) !busy |-> scl_out)
        else $error("SCL low while idle");

endmodule

bind i2c_master_top i2c_master_chk chk (
    .pclk        (pclk),
    .arst_n      (arst_n),
    .scl_out     (scl_out),
    .sda_out     (sda_out),
    .pready      (pready),
    .busy        (busy),
    .start_pulse (start_pulse)
);

//--- bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic pclk,
    output logic arst_n
);

    initial begin
        pclk = 1'b0;
        forever #5 pclk = ~pclk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (5) @(posedge pclk);
        arst_n <= 1'b1;
    end

endmodule

//--- logic/i2c_master_top.sv
`timescale 1ns/1ps

module i2c_master_top (
    input  logic                        pclk,
    input  logic                        arst_n,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [i2c_pkg::addr_w-1:0]  paddr,
    input  logic [i2c_pkg::data_w-1:0]  pwdata,
    output logic [i2c_pkg::data_w-1:0]  prdata,
    output logic                        pready,
    output logic                        scl_out,
    output logic                        sda_out,
    input  logic                        sda_in
);

    logic                       tx_push_valid;
    logic                       tx_push_ready;
    logic [i2c_pkg::data_w-1:0] tx_push_data;
    logic                       tx_valid;
    logic                       tx_ready;
    logic [i2c_pkg::data_w-1:0] tx_data;
    logic                       rx_valid;
    logic                       rx_ready;
    logic [i2c_pkg::data_w-1:0] rx_data;
    logic                       rx_out_valid;
    logic                       rx_pop;
    logic [i2c_pkg::data_w-1:0] rx_out_data;
    logic [i2c_pkg::data_w-1:0] prescale;
    logic [i2c_pkg::data_w-1:0] target_addr;
    logic                       start_pulse;
    logic                       read_mode;
    logic [3:0]                 read_len;
    logic                       busy;
    logic                       nack;

    apb_regs regs (
        .pclk          (pclk),
        .arst_n        (arst_n),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .tx_push_ready (tx_push_ready),
        .rx_out_valid  (rx_out_valid),
        .rx_out_data   (rx_out_data),
        .busy          (busy),
        .nack          (nack),
        .prdata        (prdata),
        .pready        (pready),
        .tx_push_valid (tx_push_valid),
        .tx_push_data  (tx_push_data),
        .rx_pop        (rx_pop),
        .prescale      (prescale),
        .target_addr   (target_addr),
        .start_pulse   (start_pulse),
        .read_mode     (read_mode),
        .read_len      (read_len)
    );

    byte_fifo tx_fifo (
        .pclk      (pclk),
        .arst_n    (arst_n),
        .in_valid  (tx_push_valid),
        .in_data   (tx_push_data),
        .out_ready (tx_ready),
        .in_ready  (tx_push_ready),
        .out_valid (tx_valid),
        .out_data  (tx_data)
    );

    i2c_bit_engine engine (
        .pclk        (pclk),
        .arst_n      (arst_n),
        .prescale    (prescale),
        .target_addr (target_addr),
        .start_pulse (start_pulse),
        .read_mode   (read_mode),
        .read_len    (read_len),
        .tx_valid    (tx_valid),
        .tx_data     (tx_data),
        .rx_ready    (rx_ready),
        .sda_in      (sda_in),
        .tx_ready    (tx_ready),
        .rx_valid    (rx_valid),
        .rx_data     (rx_data),
        .busy        (busy),
        .nack        (nack),
        .scl_out     (scl_out),
        .sda_out     (sda_out)
    );

    byte_fifo rx_fifo (
        .pclk      (pclk),
        .arst_n    (arst_n),
        .in_valid  (rx_valid),
        .in_data   (rx_data),
        .out_ready (rx_pop),
        .in_ready  (rx_ready),
        .out_valid (rx_out_valid),
        .out_data  (rx_out_data)
    );

endmodule

//--- logic/i2c_bit_engine.sv
`timescale 1ns/1ps

module i2c_bit_engine (
    input  logic                        pclk,
    input  logic                        arst_n,
    input  logic [i2c_pkg::data_w-1:0]  prescale,
    input  logic [i2c_pkg::data_w-1:0]  target_addr,
    input  logic                        start_pulse,
    input  logic                        read_mode,
    input  logic [3:0]                  read_len,
    input  logic                        tx_valid,
    input  logic [i2c_pkg::data_w-1:0]  tx_data,
    input  logic                        rx_ready,
    input  logic                        sda_in,
    output logic                        tx_ready,
    output logic                        rx_valid,
    output logic [i2c_pkg::data_w-1:0]  rx_data,
    output logic                        busy,
    output logic                        nack,
    output logic                        scl_out,
    output logic                        sda_out
);

    i2c_pkg::engine_state_t     state;
    logic [i2c_pkg::data_w-1:0] qcnt;
    logic [1:0]                 phase;
    logic [2:0]                 bit_cnt;
    logic [3:0]                 byte_cnt;
    logic [i2c_pkg::data_w-1:0] shift_reg;
    logic                       sda_r;
    logic                       nack_r;
    logic                       rx_taken;
    logic                       quarter_tick;
    logic                       stall;
    logic                       advance;
    logic                       bit_end;
    logic                       last_byte;

    // Phases 0,1 SCL low, 2,3 SCL high
    assign quarter_tick = (qcnt == prescale);
    // Back-pressure holds SCL low until the byte is taken
    assign stall     = (state == i2c_pkg::rd_ack) && (phase == 2'd1) && !rx_taken;
    assign advance   = quarter_tick && !stall;
    assign bit_end   = advance && (phase == 2'd3);
    assign last_byte = (byte_cnt == read_len);

    assign tx_ready = bit_end && !nack_r && !read_mode &&
                      ((state == i2c_pkg::addr_ack) || (state == i2c_pkg::wr_ack));
    assign rx_valid = (state == i2c_pkg::rd_ack) && !rx_taken;
    assign rx_data  = shift_reg;
    assign busy     = (state != i2c_pkg::idle);
    assign nack     = nack_r;
    assign scl_out  = (state == i2c_pkg::idle) || (state == i2c_pkg::start) || phase[1];
    assign sda_out  = sda_r;

    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= i2c_pkg::idle;
            qcnt     <= '0;
            phase    <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
            sda_r    <= 1'b1;
            nack_r   <= 1'b0;
            rx_taken <= 1'b0;
        end else if (state == i2c_pkg::idle) begin
            qcnt  <= '0;
            phase <= '0;
            if (start_pulse) begin
                state    <= i2c_pkg::start;
                nack_r   <= 1'b0;
                byte_cnt <= '0;
            end
        end else begin
            qcnt <= quarter_tick ? '0 : qcnt + 1'b1;
            if (rx_valid && rx_ready) rx_taken <= 1'b1;
            if (advance) begin
                phase <= phase + 1'b1;
                case (phase)
                    2'd0: begin
                        // Data changes a quarter after SCL falls
                        case (state)
                            i2c_pkg::addr, i2c_pkg::wr_byte: sda_r <= shift_reg[7];
                            i2c_pkg::rd_ack: sda_r <= last_byte;
                            i2c_pkg::stop:   sda_r <= 1'b0;
                            i2c_pkg::start:  sda_r <= sda_r;
                            default:         sda_r <= 1'b1;
                        endcase
                    end
                    2'd1: if (state == i2c_pkg::start) sda_r <= 1'b0;
                    2'd2: begin
                        if (state == i2c_pkg::stop) sda_r <= 1'b1;
                        if ((state == i2c_pkg::addr_ack) || (state == i2c_pkg::wr_ack)) begin
                            nack_r <= sda_in;
                        end
                    end
                    default: ;
                endcase
            end
            if (bit_end) begin
                rx_taken <= 1'b0;
                case (state)
                    i2c_pkg::start: begin
                        state   <= i2c_pkg::addr;
                        bit_cnt <= 3'd7;
                    end
                    i2c_pkg::addr, i2c_pkg::wr_byte, i2c_pkg::rd_byte: begin
                        bit_cnt <= bit_cnt - 1'b1;
                        if (bit_cnt == 3'd0) begin
                            case (state)
                                i2c_pkg::addr:    state <= i2c_pkg::addr_ack;
                                i2c_pkg::wr_byte: state <= i2c_pkg::wr_ack;
                                default:          state <= i2c_pkg::rd_ack;
                            endcase
                        end
                    end
                    i2c_pkg::addr_ack, i2c_pkg::wr_ack: begin
                        bit_cnt <= 3'd7;
                        if (nack_r) state <= i2c_pkg::stop;
                        else if (read_mode && (state == i2c_pkg::addr_ack)) begin
                            state <= i2c_pkg::rd_byte;
                        end
                        else if (tx_valid) state <= i2c_pkg::wr_byte;
                        else state <= i2c_pkg::stop;
                    end
                    i2c_pkg::rd_ack: begin
                        bit_cnt  <= 3'd7;
                        byte_cnt <= byte_cnt + 1'b1;
                        state    <= last_byte ? i2c_pkg::stop : i2c_pkg::rd_byte;
                    end
                    default: state <= i2c_pkg::idle;
                endcase
            end
        end
    end

    // Byte shifter, MSB first
    always_ff @(posedge pclk) begin
        if ((state == i2c_pkg::idle) && start_pulse) begin
            shift_reg <= {target_addr[6:0], read_mode};
        end else if (tx_ready && tx_valid) begin
            shift_reg <= tx_data;
        end else if (bit_end && ((state == i2c_pkg::addr) || (state == i2c_pkg::wr_byte))) begin
            shift_reg <= {shift_reg[6:0], 1'b0};
        end else if (advance && (phase == 2'd2) && (state == i2c_pkg::rd_byte)) begin
            shift_reg <= {shift_reg[6:0], sda_in};
        end
    end

endmodule

//--- logic/byte_fifo.sv
`timescale 1ns/1ps

module byte_fifo (
    input  logic                        pclk,
    input  logic                        arst_n,
    input  logic                        in_valid,
    input  logic [i2c_pkg::data_w-1:0]  in_data,
    input  logic                        out_ready,
    output logic                        in_ready,
    output logic                        out_valid,
    output logic [i2c_pkg::data_w-1:0]  out_data
);

    logic [i2c_pkg::data_w-1:0] mem [i2c_pkg::fifo_depth];
    logic [i2c_pkg::ptr_w:0]    wr_ptr;
    logic [i2c_pkg::ptr_w:0]    rd_ptr;
    logic                       push;
    logic                       pop;

    // Extra pointer bit tells full from empty
    assign in_ready  = !((wr_ptr[i2c_pkg::ptr_w] != rd_ptr[i2c_pkg::ptr_w]) &&
                         (wr_ptr[i2c_pkg::ptr_w-1:0] == rd_ptr[i2c_pkg::ptr_w-1:0]));
    assign out_valid = (wr_ptr != rd_ptr);
    assign out_data  = mem[rd_ptr[i2c_pkg::ptr_w-1:0]];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge pclk) begin
        if (push) begin
            mem[wr_ptr[i2c_pkg::ptr_w-1:0]] <= in_data;
        end
    end

    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

//--- logic/apb_regs.sv
`timescale 1ns/1ps

module apb_regs (
    input  logic                        pclk,
    input  logic                        arst_n,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [i2c_pkg::addr_w-1:0]  paddr,
    input  logic [i2c_pkg::data_w-1:0]  pwdata,
    input  logic                        tx_push_ready,
    input  logic                        rx_out_valid,
    input  logic [i2c_pkg::data_w-1:0]  rx_out_data,
    input  logic                        busy,
    input  logic                        nack,
    output logic [i2c_pkg::data_w-1:0]  prdata,
    output logic                        pready,
    output logic                        tx_push_valid,
    output logic [i2c_pkg::data_w-1:0]  tx_push_data,
    output logic                        rx_pop,
    output logic [i2c_pkg::data_w-1:0]  prescale,
    output logic [i2c_pkg::data_w-1:0]  target_addr,
    output logic                        start_pulse,
    output logic                        read_mode,
    output logic [3:0]                  read_len
);

    logic                       wr_en;
    logic                       rd_en;
    logic [i2c_pkg::data_w-1:0] status;
    logic [i2c_pkg::data_w-1:0] command;

    assign wr_en  = psel && penable && pwrite;
    assign rd_en  = psel && penable && !pwrite;
    assign pready = 1'b1;

    // Transmit push goes straight to the FIFO, dropped when full
    assign tx_push_valid = wr_en && (paddr == i2c_pkg::reg_transmit);
    assign tx_push_data  = pwdata;
    assign rx_pop        = rd_en && (paddr == i2c_pkg::reg_receive) && rx_out_valid;

    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            prescale    <= '0;
            target_addr <= '0;
            read_mode   <= 1'b0;
            read_len    <= '0;
            start_pulse <= 1'b0;
        end else begin
            start_pulse <= 1'b0;
            if (wr_en) begin
                case (paddr)
                    i2c_pkg::reg_prescale: prescale <= pwdata;
                    i2c_pkg::reg_address:  target_addr <= pwdata;
                    i2c_pkg::reg_command: begin
                        read_mode   <= pwdata[i2c_pkg::cmd_read];
                        read_len    <= pwdata[i2c_pkg::cmd_len_lsb +: 4];
                        // One cycle late so the engine sees the new mode and length
                        start_pulse <= pwdata[i2c_pkg::cmd_start];
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        status                       = '0;
        status[i2c_pkg::st_busy]     = busy;
        status[i2c_pkg::st_nack]     = nack;
        status[i2c_pkg::st_tx_full]  = !tx_push_ready;
        status[i2c_pkg::st_rx_empty] = !rx_out_valid;
    end

    always_comb begin
        command                              = '0;
        command[i2c_pkg::cmd_read]           = read_mode;
        command[i2c_pkg::cmd_len_lsb +: 4]   = read_len;
    end

    // Read mux
    always_comb begin
        case (paddr)
            i2c_pkg::reg_prescale: prdata = prescale;
            i2c_pkg::reg_command:  prdata = command;
            i2c_pkg::reg_status:   prdata = status;
            i2c_pkg::reg_receive:  prdata = rx_out_valid ? rx_out_data : '0;
            i2c_pkg::reg_address:  prdata = target_addr;
            default:               prdata = '0;
        endcase
    end

endmodule

//--- logic/i2c_pkg.sv
package i2c_pkg;

    localparam int data_w     = 8;
    localparam int addr_w     = 3;
    localparam int fifo_depth = 8;
    localparam int ptr_w      = 3;

    // Register map
    localparam logic [addr_w-1:0] reg_prescale = 3'd0;
    localparam logic [addr_w-1:0] reg_command  = 3'd1;
    localparam logic [addr_w-1:0] reg_status   = 3'd2;
    localparam logic [addr_w-1:0] reg_transmit = 3'd3;
    localparam logic [addr_w-1:0] reg_receive  = 3'd4;
    localparam logic [addr_w-1:0] reg_address  = 3'd5;

    // Command bits, read length sits in 7:4
    localparam int cmd_start   = 0;
    localparam int cmd_read    = 1;
    localparam int cmd_len_lsb = 4;

    // Status bits
    localparam int st_busy     = 0;
    localparam int st_nack     = 1;
    localparam int st_tx_full  = 2;
    localparam int st_rx_empty = 3;

    typedef enum logic [3:0] {
        idle, start, addr, addr_ack, wr_byte, wr_ack, rd_byte, rd_ack, stop
    } engine_state_t;

endpackage
